//--- files.f
+incdir+source
source/noc_pkg.sv
source/buffer_pkg.sv
source/vc_pointer_bank.sv
source/flit_ram.sv
source/input_buffer.sv
tests/input_buffer_chk.sv
tests/input_buffer_tb.sv

//--- Makefile
TOP := input_buffer_tb
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f files.f --top-module $(TOP) -Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ)

//--- tests/input_buffer_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_settings.svh"

module input_buffer_tb;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 4;
    localparam int RANDOM_CYCLES   = 400;
    localparam int DIRECTED_CYCLES = `NOC_NUM_VC * (2 * `NOC_VC_DEPTH + 2) + 40;
    // twice the expected run length
    localparam int WATCHDOG_NS =
        CLK_PERIOD * 2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES);

    logic              clk;
    logic              reset;
    logic              wr_en;
    logic              rd_en;
    noc_pkg::vc_mask_t wr_vc;
    noc_pkg::vc_mask_t rd_vc;
    noc_pkg::vc_mask_t ssa_rd;
    noc_pkg::flit_t    wr_flit;
    noc_pkg::flit_t    rd_flit;
    noc_pkg::vc_mask_t vc_not_empty;

    // lfsr state, seeded
    logic [31:0] lfsr_state = 32'hd0c6;

    // reference queues, one per vc
    noc_pkg::flit_t ref_q [`NOC_NUM_VC][$];

    // expectation for the coming edge, set with the stimulus
    noc_pkg::flit_t    next_flit;
    noc_pkg::vc_mask_t next_mask;
    logic              next_valid = 1'b0;

    // expectation for the outputs now on the DUT
    noc_pkg::flit_t    exp_flit;
    noc_pkg::vc_mask_t exp_mask;
    logic              exp_valid = 1'b0;

    logic run_passed = 1'b0;
    logic fail_shown = 1'b0;

    input_buffer dut_i (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .wr_vc        (wr_vc),
        .rd_vc        (rd_vc),
        .ssa_rd       (ssa_rd),
        .wr_flit      (wr_flit),
        .rd_flit      (rd_flit),
        .vc_not_empty (vc_not_empty)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // fibonacci taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[31]};
        end
        return value;
    endfunction

    function automatic noc_pkg::flit_t random_flit();
        noc_pkg::flit_t f;
        logic [31:0]    bits;
        bits = rand_bits(2);
        f.kind = noc_pkg::flit_kind_t'(bits[1:0]);
        f.payload = rand_bits(`NOC_PAYLOAD_W);
        return f;
    endfunction

    function automatic noc_pkg::vc_mask_t vc_select(input int v);
        return noc_pkg::vc_mask_t'(1) << v;
    endfunction

    // reference model of one edge
    // a read returns the oldest flit, no read returns the write data
    function automatic noc_pkg::flit_t ref_step(
        input logic              w_en,
        input noc_pkg::vc_mask_t w_vc,
        input noc_pkg::flit_t    w_flit,
        input logic              r_en,
        input noc_pkg::vc_mask_t r_vc,
        input noc_pkg::vc_mask_t ssa
    );
        noc_pkg::flit_t result;
        result = w_flit;
        for (int v = 0; v < `NOC_NUM_VC; v++) begin
            // oldest taken before the new flit joins
            if (r_en && r_vc[v]) begin
                result = ref_q[v].pop_front();
            end
        end
        for (int v = 0; v < `NOC_NUM_VC; v++) begin
            if (w_en && w_vc[v]) begin
                ref_q[v].push_back(w_flit);
            end
        end
        // bypassed flits leave the queue
        if (!r_en) begin
            for (int v = 0; v < `NOC_NUM_VC; v++) begin
                if (ssa[v]) begin
                    void'(ref_q[v].pop_front());
                end
            end
        end
        return result;
    endfunction

    function automatic noc_pkg::vc_mask_t ref_mask();
        noc_pkg::vc_mask_t m;
        for (int v = 0; v < `NOC_NUM_VC; v++) begin
            m[v] = (ref_q[v].size() != 0);
        end
        return m;
    endfunction

    task automatic abort_run();
        fail_shown = 1'b1;
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_flit(
        input noc_pkg::flit_t got,
        input noc_pkg::flit_t exp,
        input string          what
    );
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is kind %0d payload %h, expected kind %0d payload %h",
                $time, what, got.kind, got.payload, exp.kind, exp.payload);
            abort_run();
        end
    endtask

    task automatic check_mask(
        input noc_pkg::vc_mask_t got,
        input noc_pkg::vc_mask_t exp,
        input string             what
    );
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // one cycle of stimulus on the falling edge
    task automatic drive_cycle(
        input logic              w_en,
        input noc_pkg::vc_mask_t w_vc,
        input noc_pkg::flit_t    w_flit,
        input logic              r_en,
        input noc_pkg::vc_mask_t r_vc,
        input noc_pkg::vc_mask_t ssa
    );
        @(negedge clk);
        wr_en   = w_en;
        wr_vc   = w_vc;
        wr_flit = w_flit;
        rd_en   = r_en;
        rd_vc   = r_vc;
        ssa_rd  = ssa;
        next_flit  = ref_step(w_en, w_vc, w_flit, r_en, r_vc, ssa);
        next_mask  = ref_mask();
        next_valid = 1'b1;
    endtask

    // outputs before the edge belong to the previous edge
    initial begin
        forever begin
            @(posedge clk);
            if (exp_valid) begin
                check_flit(rd_flit, exp_flit, "rd_flit");
                check_mask(vc_not_empty, exp_mask, "vc_not_empty");
            end
            exp_flit  = next_flit;
            exp_mask  = next_mask;
            exp_valid = next_valid;
        end
    end

    task automatic fill_and_drain(input int v);
        for (int i = 0; i < `NOC_VC_DEPTH; i++) begin
            drive_cycle(1'b1, vc_select(v), random_flit(), 1'b0, '0, '0);
        end
        for (int i = 0; i < `NOC_VC_DEPTH; i++) begin
            drive_cycle(1'b0, '0, random_flit(), 1'b1, vc_select(v), '0);
        end
        // flag must be clear here
        drive_cycle(1'b0, '0, random_flit(), 1'b0, '0, '0);
    endtask

    // occupancy held while reading and writing the same vc
    task automatic same_vc_read_write(input int v);
        repeat (2) drive_cycle(1'b1, vc_select(v), random_flit(), 1'b0, '0, '0);
        repeat (4) drive_cycle(1'b1, vc_select(v), random_flit(), 1'b1, vc_select(v), '0);
        repeat (2) drive_cycle(1'b0, '0, random_flit(), 1'b1, vc_select(v), '0);
    endtask

    // vc must be empty on entry
    task automatic ssa_bypass(input int v);
        repeat (2) drive_cycle(1'b1, vc_select(v), random_flit(), 1'b0, '0, vc_select(v));
        // bypass also shows data that was never written
        drive_cycle(1'b0, '0, random_flit(), 1'b0, '0, '0);
    endtask

    task automatic random_traffic(input int cycles);
        int                rv;
        int                wv;
        logic              r_en;
        logic              w_en;
        noc_pkg::vc_mask_t ssa;
        for (int n = 0; n < cycles; n++) begin
            rv = int'(rand_bits(8)) % `NOC_NUM_VC;
            wv = int'(rand_bits(8)) % `NOC_NUM_VC;
            r_en = (rand_bits(1) != 0) && (ref_q[rv].size() > 0);
            // full vc only when it is read too
            w_en = (rand_bits(2) != 0)
                && ((ref_q[wv].size() < `NOC_VC_DEPTH) || (r_en && rv == wv));
            ssa = '0;
            if (!r_en && w_en && ref_q[wv].size() == 0 && rand_bits(1) != 0) begin
                ssa = vc_select(wv);
            end
            drive_cycle(w_en, vc_select(wv), random_flit(), r_en, vc_select(rv), ssa);
        end
    endtask

    initial begin
        reset   = 1'b1;
        wr_en   = 1'b0;
        rd_en   = 1'b0;
        wr_vc   = '0;
        rd_vc   = '0;
        ssa_rd  = '0;
        wr_flit = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_mask(vc_not_empty, '0, "vc_not_empty after reset");
        for (int v = 0; v < `NOC_NUM_VC; v++) begin
            fill_and_drain(v);
        end
        same_vc_read_write((`NOC_NUM_VC > 1) ? 1 : 0);
        ssa_bypass(`NOC_NUM_VC - 1);
        random_traffic(RANDOM_CYCLES);
        // let the last expectations reach the compare process
        repeat (2) drive_cycle(1'b0, '0, random_flit(), 1'b0, '0, '0);
        repeat (2) @(negedge clk);
        run_passed = 1'b1;
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the test did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    // run stopped elsewhere, e.g. by an assertion
    final begin
        if (!run_passed && !fail_shown) begin
            $display("TEST RESULT: FAIL");
        end
    end

endmodule

`default_nettype wire

//--- tests/input_buffer_chk.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_settings.svh"

// port rules of the input buffer
// the buffer trusts its writer and reader, so these are only watched here
module input_buffer_chk (
    input logic              clk,
    input logic              reset,
    input logic              wr_en,
    input logic              rd_en,
    input noc_pkg::vc_mask_t wr_vc,
    input noc_pkg::vc_mask_t rd_vc,
    input noc_pkg::vc_mask_t ssa_rd
);

    // per-vc strobes as the buffer sees them
    noc_pkg::vc_mask_t wr_hit;
    noc_pkg::vc_mask_t rd_hit;
    noc_pkg::vc_mask_t full_vc;
    noc_pkg::vc_mask_t empty_vc;

    // shadow occupancy per vc
    int fill [`NOC_NUM_VC];

    assign wr_hit = wr_en ? wr_vc : '0;
    // ssa consume only counts when no normal read
    assign rd_hit = rd_en ? rd_vc : ssa_rd;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int v = 0; v < `NOC_NUM_VC; v++) begin
                fill[v] <= 0;
            end
        end else begin
            for (int v = 0; v < `NOC_NUM_VC; v++) begin
                if (wr_hit[v] && !rd_hit[v]) begin
                    fill[v] <= fill[v] + 1;
                end else if (!wr_hit[v] && rd_hit[v]) begin
                    fill[v] <= fill[v] - 1;
                end
            end
        end
    end

    always_comb begin
        for (int v = 0; v < `NOC_NUM_VC; v++) begin
            full_vc[v]  = (fill[v] >= `NOC_VC_DEPTH);
            empty_vc[v] = (fill[v] == 0);
        end
    end

    // full vc written only while it is also read
    no_overflow: assert property (@(posedge clk) disable iff (reset)
        ((wr_hit & full_vc & ~rd_hit) == '0))
        else $error("write to a full vc without a read of it");

    // empty vc read only while it is also written
    no_underflow: assert property (@(posedge clk) disable iff (reset)
        ((rd_hit & empty_vc & ~wr_hit) == '0))
        else $error("read of an empty vc without a write to it");

    wr_vc_onehot: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> $onehot(wr_vc))
        else $error("wr_vc is not one-hot while wr_en is high");

    rd_vc_onehot: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> $onehot(rd_vc))
        else $error("rd_vc is not one-hot while rd_en is high");

endmodule

bind input_buffer input_buffer_chk chk_i (
    .clk    (clk),
    .reset  (reset),
    .wr_en  (wr_en),
    .rd_en  (rd_en),
    .wr_vc  (wr_vc),
    .rd_vc  (rd_vc),
    .ssa_rd (ssa_rd)
);

`default_nettype wire

//--- source/input_buffer.sv
`timescale 1ns/1ns
`default_nettype none

// input buffer of one router port
// all vcs share one flit ram, each vc in a fixed region
// no back-pressure, upstream credits keep vcs from overflowing
module input_buffer (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  logic              rd_en,
    input  noc_pkg::vc_mask_t wr_vc,
    input  noc_pkg::vc_mask_t rd_vc,
    input  noc_pkg::vc_mask_t ssa_rd,
    input  noc_pkg::flit_t    wr_flit,
    output noc_pkg::flit_t    rd_flit,
    output noc_pkg::vc_mask_t vc_not_empty
);

    // ram addresses from the pointer bank
    buffer_pkg::ram_addr_t wr_addr;
    buffer_pkg::ram_addr_t rd_addr;

    // flits in ram format
    buffer_pkg::ram_word_t ram_wr_word;
    buffer_pkg::ram_word_t ram_rd_word;

    // port flit into ram word
    assign ram_wr_word.kind    = wr_flit.kind;
    assign ram_wr_word.payload = wr_flit.payload;

    // ram word back to port flit
    // valid one cycle after rd_en, or bypass data otherwise
    assign rd_flit.kind    = ram_rd_word.kind;
    assign rd_flit.payload = ram_rd_word.payload;

    // pointers, depths and address forming
    vc_pointer_bank pointer_bank_i (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .wr_vc        (wr_vc),
        .rd_vc        (rd_vc),
        .ssa_rd       (ssa_rd),
        .wr_addr      (wr_addr),
        .rd_addr      (rd_addr),
        .vc_not_empty (vc_not_empty)
    );

    // shared storage plus ssa bypass
    flit_ram flit_ram_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .wr_data (ram_wr_word),
        .rd_data (ram_rd_word)
    );

endmodule

`default_nettype wire

//--- source/flit_ram.sv
`timescale 1ns/1ns
`default_nettype none

// shared flit memory for all vcs of the port
// one write and one registered read per cycle
// output falls back to last cycle's write data when no read was made
module flit_ram (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  buffer_pkg::ram_addr_t wr_addr,
    input  buffer_pkg::ram_addr_t rd_addr,
    input  buffer_pkg::ram_word_t wr_data,
    output buffer_pkg::ram_word_t rd_data
);

    // one word per address, regions laid out vc after vc
    localparam int WORDS = 2 ** $bits(buffer_pkg::ram_addr_t);

    buffer_pkg::ram_word_t mem [WORDS];

    // registered read word
    buffer_pkg::ram_word_t mem_rd_q;

    // ssa bypass word, last cycle's write data
    buffer_pkg::ram_word_t bypass_q;

    // was the last cycle a normal read
    logic rd_en_q;

    // block ram port pair
    // read during write to the same word returns the old word,
    // which is the oldest flit of a full vc being read and written
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            mem_rd_q <= mem[rd_addr];
        end
    end

    // bypass path, loaded every cycle
    // whether or not the write data was stored
    always_ff @(posedge clk) begin
        bypass_q <= wr_data;
        rd_en_q  <= rd_en;
    end

    // memory word after a read, speculative flit otherwise
    assign rd_data = rd_en_q ? mem_rd_q : bypass_q;

endmodule

`default_nettype wire

//--- source/vc_pointer_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_settings.svh"

// per-vc queue state for the shared flit ram
// pointers wrap inside their own region, depth tracks occupancy
module vc_pointer_bank (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  noc_pkg::vc_mask_t     wr_vc,
    input  noc_pkg::vc_mask_t     rd_vc,
    input  noc_pkg::vc_mask_t     ssa_rd,
    output buffer_pkg::ram_addr_t wr_addr,
    output buffer_pkg::ram_addr_t rd_addr,
    output noc_pkg::vc_mask_t     vc_not_empty
);

    localparam buffer_pkg::slot_t  SLOT_ONE  = 1;
    localparam buffer_pkg::depth_t DEPTH_ONE = 1;

    // per-vc strobes after the enables are applied
    noc_pkg::vc_mask_t wr_strobe;
    noc_pkg::vc_mask_t rd_strobe;

    // queue state, one entry per vc
    buffer_pkg::slot_t  wr_ptr [`NOC_NUM_VC];
    buffer_pkg::slot_t  rd_ptr [`NOC_NUM_VC];
    buffer_pkg::depth_t depth  [`NOC_NUM_VC];

    // binary vc numbers for the ram address
    buffer_pkg::vc_index_t wr_idx;
    buffer_pkg::vc_index_t rd_idx;

    // one-hot to binary
    // or of the indices of the set bits, exact for a one-hot input
    function automatic buffer_pkg::vc_index_t onehot_to_index(
        input noc_pkg::vc_mask_t sel
    );
        buffer_pkg::vc_index_t idx;
        idx = '0;
        for (int v = 0; v < `NOC_NUM_VC; v++) begin
            if (sel[v]) begin
                idx = idx | buffer_pkg::vc_index_t'(v);
            end
        end
        return idx;
    endfunction

    // write only when enabled
    assign wr_strobe = wr_en ? wr_vc : '0;

    // normal read follows rd_vc
    // with no normal read, ssa_rd drops flits taken by the bypass
    assign rd_strobe = rd_en ? rd_vc : ssa_rd;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int v = 0; v < `NOC_NUM_VC; v++) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                depth[v]  <= '0;
            end
        end else begin
            for (int v = 0; v < `NOC_NUM_VC; v++) begin
                // pointers wrap by overflow, region size is a power of two
                if (wr_strobe[v]) begin
                    wr_ptr[v] <= wr_ptr[v] + SLOT_ONE;
                end
                if (rd_strobe[v]) begin
                    rd_ptr[v] <= rd_ptr[v] + SLOT_ONE;
                end
                // write and read together leave depth as is
                if (wr_strobe[v] && !rd_strobe[v]) begin
                    depth[v] <= depth[v] + DEPTH_ONE;
                end else if (!wr_strobe[v] && rd_strobe[v]) begin
                    depth[v] <= depth[v] - DEPTH_ONE;
                end
            end
        end
    end

    // occupancy flags
    always_comb begin
        for (int v = 0; v < `NOC_NUM_VC; v++) begin
            vc_not_empty[v] = (depth[v] != '0);
        end
    end

    assign wr_idx = onehot_to_index(wr_vc);
    assign rd_idx = onehot_to_index(rd_vc);

    // region from the vc number, word from that vc's pointer
    assign wr_addr.vc   = wr_idx;
    assign wr_addr.slot = wr_ptr[wr_idx];

    // ssa consumes never touch the ram, only rd_vc addresses it
    assign rd_addr.vc   = rd_idx;
    assign rd_addr.slot = rd_ptr[rd_idx];

endmodule

`default_nettype wire

//--- source/buffer_pkg.sv
`default_nettype none

`include "noc_settings.svh"

// types private to the input buffer
package buffer_pkg;

    // slot bits inside one vc region
    // kept at one bit minimum so a depth of one still builds
    localparam int SLOT_W = (`NOC_VC_DEPTH > 1) ? $clog2(`NOC_VC_DEPTH) : 1;

    // binary vc number bits, same one bit minimum
    localparam int VC_W = (`NOC_NUM_VC > 1) ? $clog2(`NOC_NUM_VC) : 1;

    // read or write pointer of one vc
    typedef logic [SLOT_W-1:0] slot_t;

    // binary form of a one-hot vc select
    typedef logic [VC_W-1:0] vc_index_t;

    // occupancy of one vc, 0 up to NOC_VC_DEPTH
    // one bit above the pointer so full and empty differ
    typedef logic [SLOT_W:0] depth_t;

    // shared ram address
    // vc number picks the region, slot the word inside it
    typedef struct packed {
        vc_index_t vc;
        slot_t     slot;
    } ram_addr_t;

    // stored word
    // same layout as the port flit, kept apart so the
    // ram format can change without touching the port
    typedef struct packed {
        noc_pkg::flit_kind_t       kind;
        logic [`NOC_PAYLOAD_W-1:0] payload;
    } ram_word_t;

endpackage

`default_nettype wire

//--- source/noc_pkg.sv
`default_nettype none

`include "noc_settings.svh"

// types seen at the router port boundary
package noc_pkg;

    // vc select, one-hot or all zero
    // bit n stands for vc n
    typedef logic [`NOC_NUM_VC-1:0] vc_mask_t;

    // packet position of a flit
    // upper bit marks a head, lower bit marks a tail
    // single-flit packets carry both
    typedef enum logic [1:0] {
        FLIT_BODY   = 2'b00,
        FLIT_TAIL   = 2'b01,
        FLIT_HEAD   = 2'b10,
        FLIT_SINGLE = 2'b11
    } flit_kind_t;

    // flit as it crosses the port
    // kind sits above the payload, as on the link
    typedef struct packed {
        flit_kind_t                kind;
        logic [`NOC_PAYLOAD_W-1:0] payload;
    } flit_t;

    // the vc id is not part of the flit here
    // the router passes it beside the flit as a select mask

endpackage

`default_nettype wire

//--- source/noc_settings.svh
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// router port build settings
// shared by both packages and the RTL

// number of virtual channels on this input port
// one bit per vc in every select mask
`define NOC_NUM_VC 4

// flits held per vc
// must be a power of two so pointers wrap by overflow
// every vc owns one region of this size in the shared ram
`define NOC_VC_DEPTH 4

// payload bits per flit without the kind bits
`define NOC_PAYLOAD_W 32

`endif
